/* common/uart_loader_pkg.sv */
`default_nettype none

package uart_loader_pkg;

    // link timing kept short for simulation
    localparam int clks_per_tick = 4;
    localparam int ticks_per_bit = 16;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    localparam int seed_words = 16;
    localparam int pk_words   = 64;

    typedef logic [5:0]  addr_t;
    typedef logic [23:0] len_t;

    typedef enum logic [2:0] {
        cmd_none       = 3'd0,
        cmd_write_pk   = 3'd1,
        cmd_write_seed = 3'd2,
        cmd_read_seed  = 3'd3,
        cmd_read_pk    = 3'd4
    } cmd_e;

    localparam byte_t ack_byte = 8'h01;

    // first length byte as short length or long-form flag plus byte count
    typedef union packed {
        byte_t raw;
        struct packed {
            logic       long_form;
            logic [6:0] count;
        } f;
    } len_byte_u;

endpackage

`default_nettype wire

/* compile.f */
common/uart_loader_pkg.sv
uart/uart_baud_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/tlv_decoder.sv
src/word_store.sv
src/reply_sender.sv
src/uart_loader_top.sv
tb/uart_loader_asserts.sv
tb/uart_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the uart loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module uart_loader_tb \
    -f compile.f -o uart_loader_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/uart_loader_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* src/reply_sender.sv */
`timescale 1ns/100ps
`default_nettype none

module reply_sender
    import uart_loader_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  write_done,
    input  cmd_e  frame_cmd,
    input  logic  frame_end,
    input  logic  tx_busy,
    input  logic  tx_done,
    output logic  rd_sel,
    output addr_t rd_addr,
    input  word_t rd_data,
    output logic  tx_start,
    output byte_t tx_byte
);
    typedef enum logic [1:0] {st_idle, st_fetch, st_load, st_send} state_t;

    state_t     state;
    word_t      word_buf;
    logic [1:0] byte_idx;
    logic       more;
    addr_t      last_addr;
    logic       read_req;

    assign read_req = frame_end && (frame_cmd == cmd_read_seed || frame_cmd == cmd_read_pk);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= st_idle;
            tx_start  <= 1'b0;
            rd_sel    <= 1'b0;
            rd_addr   <= '0;
            byte_idx  <= '0;
            more      <= 1'b0;
            last_addr <= '0;
        end
        else
        begin
            tx_start <= 1'b0;
            case (state)
                st_idle:
                    if (!tx_busy)
                    begin
                        if (write_done)
                        begin
                            // ack is a one-byte word with nothing after it
                            tx_byte  <= ack_byte;
                            tx_start <= 1'b1;
                            byte_idx <= 2'd3;
                            more     <= 1'b0;
                            state    <= st_send;
                        end
                        else if (read_req)
                        begin
                            rd_sel    <= (frame_cmd == cmd_read_pk);
                            last_addr <= (frame_cmd == cmd_read_pk) ? addr_t'(pk_words - 1)
                                                                    : addr_t'(seed_words - 1);
                            rd_addr   <= '0;
                            state     <= st_fetch;
                        end
                    end
                // one clock of read latency
                st_fetch: state <= st_load;
                st_load:
                begin
                    word_buf <= rd_data;
                    tx_byte  <= rd_data[31:24];
                    tx_start <= 1'b1;
                    byte_idx <= '0;
                    state    <= st_send;
                end
                st_send:
                    if (tx_done)
                    begin
                        if (byte_idx == 2'd3)
                        begin
                            if (more)
                            begin
                                word_buf <= rd_data;
                                tx_byte  <= rd_data[31:24];
                                tx_start <= 1'b1;
                                byte_idx <= '0;
                            end
                            else
                            begin
                                state <= st_idle;
                            end
                        end
                        else
                        begin
                            tx_byte  <= word_buf[23:16];
                            word_buf <= word_buf << 8;
                            tx_start <= 1'b1;
                            byte_idx <= byte_idx + 2'd1;
                            // next word is read while the last byte goes out
                            if (byte_idx == 2'd2)
                            begin
                                if (rd_addr == last_addr)
                                begin
                                    more <= 1'b0;
                                end
                                else
                                begin
                                    rd_addr <= rd_addr + addr_t'(1);
                                    more    <= 1'b1;
                                end
                            end
                        end
                    end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/tlv_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module tlv_decoder
    import uart_loader_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rx_valid,
    input  byte_t rx_byte,
    output cmd_e  frame_cmd,
    output logic  frame_start,
    output logic  value_valid,
    output byte_t value_byte,
    output logic  frame_end
);
    typedef enum logic [1:0] {st_idle, st_type, st_length, st_value} state_t;

    state_t     state;
    len_byte_u  len_first;
    logic [6:0] len_bytes;
    len_t       len_left;
    cmd_e       type_cmd;

    assign len_first.raw = rx_byte;

    always_comb
    begin
        case (rx_byte)
            8'd1:    type_cmd = cmd_write_pk;
            8'd2:    type_cmd = cmd_write_seed;
            8'd3:    type_cmd = cmd_read_seed;
            8'd4:    type_cmd = cmd_read_pk;
            default: type_cmd = cmd_none;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= st_idle;
            frame_cmd   <= cmd_none;
            frame_start <= 1'b0;
            value_valid <= 1'b0;
            frame_end   <= 1'b0;
            len_bytes   <= '0;
            len_left    <= '0;
        end
        else
        begin
            frame_start <= 1'b0;
            value_valid <= 1'b0;
            frame_end   <= 1'b0;
            case (state)
                st_idle:
                    // zero bytes between frames are padding
                    if (rx_valid && rx_byte != 8'h00)
                    begin
                        frame_cmd <= type_cmd;
                        state     <= st_type;
                    end
                st_type:
                    if (rx_valid)
                    begin
                        if (len_first.f.long_form && len_first.f.count != 7'd0)
                        begin
                            len_bytes <= len_first.f.count;
                            len_left  <= '0;
                            state     <= st_length;
                        end
                        else
                        begin
                            len_left    <= len_first.f.long_form ? '0 : len_t'(len_first.f.count);
                            frame_start <= 1'b1;
                            state       <= st_value;
                        end
                    end
                st_length:
                    if (rx_valid)
                    begin
                        // big-endian length bytes
                        len_left  <= {len_left[15:0], rx_byte};
                        len_bytes <= len_bytes - 7'd1;
                        if (len_bytes == 7'd1)
                        begin
                            frame_start <= 1'b1;
                            state       <= st_value;
                        end
                    end
                st_value:
                    if (len_left == '0)
                    begin
                        frame_end <= 1'b1;
                        state     <= st_idle;
                    end
                    else if (rx_valid)
                    begin
                        value_valid <= 1'b1;
                        value_byte  <= rx_byte;
                        len_left    <= len_left - len_t'(1);
                        if (len_left == len_t'(1))
                        begin
                            frame_end <= 1'b1;
                            state     <= st_idle;
                        end
                    end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/uart_loader_top.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_loader_top
    import uart_loader_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic uart_rx_in,
    output logic uart_tx_out
);
    logic  tick;
    logic  rx_valid;
    byte_t rx_byte;
    cmd_e  frame_cmd;
    logic  frame_start;
    logic  value_valid;
    byte_t value_byte;
    logic  frame_end;
    logic  write_done;
    logic  rd_sel;
    addr_t rd_addr;
    word_t rd_data;
    logic  tx_start;
    byte_t tx_byte;
    logic  tx_busy;
    logic  tx_done;

    uart_baud_gen uart_baud_gen_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx uart_rx_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .rx       (uart_rx_in),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    tlv_decoder tlv_decoder_inst (
        .clk         (clk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .frame_cmd   (frame_cmd),
        .frame_start (frame_start),
        .value_valid (value_valid),
        .value_byte  (value_byte),
        .frame_end   (frame_end)
    );

    word_store word_store_inst (
        .clk         (clk),
        .rst         (rst),
        .frame_cmd   (frame_cmd),
        .frame_start (frame_start),
        .value_valid (value_valid),
        .value_byte  (value_byte),
        .frame_end   (frame_end),
        .rd_sel      (rd_sel),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .write_done  (write_done)
    );

    reply_sender reply_sender_inst (
        .clk        (clk),
        .rst        (rst),
        .write_done (write_done),
        .frame_cmd  (frame_cmd),
        .frame_end  (frame_end),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done),
        .rd_sel     (rd_sel),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (uart_tx_out),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

endmodule

`default_nettype wire

/* src/word_store.sv */
`timescale 1ns/100ps
`default_nettype none

module word_store
    import uart_loader_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  cmd_e  frame_cmd,
    input  logic  frame_start,
    input  logic  value_valid,
    input  byte_t value_byte,
    input  logic  frame_end,
    input  logic  rd_sel,
    input  addr_t rd_addr,
    output word_t rd_data,
    output logic  write_done
);
    localparam int seed_aw = $clog2(seed_words);

    word_t      seed_mem [seed_words];
    word_t      pk_mem [pk_words];
    word_t      pack;
    logic [1:0] byte_idx;
    logic       wr_en;
    logic       mem_full;
    addr_t      wr_addr;
    addr_t      wr_last;
    logic       is_write;

    assign is_write = (frame_cmd == cmd_write_pk) || (frame_cmd == cmd_write_seed);
    assign wr_last  = (frame_cmd == cmd_write_pk) ? addr_t'(pk_words - 1)
                                                  : addr_t'(seed_words - 1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            byte_idx   <= '0;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            mem_full   <= 1'b0;
            write_done <= 1'b0;
        end
        else
        begin
            write_done <= frame_end && is_write;
            wr_en      <= 1'b0;
            if (frame_start)
            begin
                byte_idx <= '0;
                wr_addr  <= '0;
                mem_full <= 1'b0;
            end
            else
            begin
                if (value_valid)
                begin
                    byte_idx <= byte_idx + 2'd1;
                    // a complete word goes out on the next clock
                    if (byte_idx == 2'd3 && is_write && !mem_full)
                    begin
                        wr_en <= 1'b1;
                    end
                end
                if (wr_en)
                begin
                    if (wr_addr == wr_last)
                    begin
                        mem_full <= 1'b1;
                    end
                    else
                    begin
                        wr_addr <= wr_addr + addr_t'(1);
                    end
                end
            end
        end
    end

    // msb first packing
    always_ff @(posedge clk)
    begin
        if (value_valid)
        begin
            pack <= {pack[23:0], value_byte};
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            if (frame_cmd == cmd_write_pk)
            begin
                pk_mem[wr_addr] <= pack;
            end
            else
            begin
                seed_mem[wr_addr[seed_aw-1:0]] <= pack;
            end
        end
        rd_data <= rd_sel ? pk_mem[rd_addr] : seed_mem[rd_addr[seed_aw-1:0]];
    end

endmodule

`default_nettype wire

/* tb/uart_loader_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_loader_asserts
(
    input wire logic clk,
    input wire logic rst,
    input wire logic rx_valid,
    input wire logic tx_start,
    input wire logic tx_busy,
    input wire logic uart_tx_out
);
    int fail_count = 0;

    // receive strobe is a single clock
    rx_valid_pulse: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
    else
    begin
        fail_count++;
        $error("rx_valid held for more than one clock");
    end

    tx_start_idle: assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
    else
    begin
        fail_count++;
        $error("tx_start while tx_busy is high");
    end

    // line idles high once reset has been seen
    tx_idle_after_reset: assert property (@(posedge clk) rst |=> uart_tx_out)
    else
    begin
        fail_count++;
        $error("uart_tx_out not high after reset");
    end

endmodule

bind uart_loader_top uart_loader_asserts uart_loader_asserts_inst (
    .clk         (clk),
    .rst         (rst),
    .rx_valid    (rx_valid),
    .tx_start    (tx_start),
    .tx_busy     (tx_busy),
    .uart_tx_out (uart_tx_out)
);

`default_nettype wire

/* tb/uart_loader_patterns.txt */
// record: frame entry count, frame entries, reply entry count, reply entries
// entry 000xx one byte, 1nnnn nnnn random bytes, 2ssnn nn fill bytes from index ss
// type 2 with 64 fill bytes, acknowledged
00003 00002 00040 20040   00001 00001
// type 3 reads the seed memory back
00002 00003 00000   00001 20040
// type 1, long length 0x0100, random data
00005 00001 00082 00001 00000 10100   00001 00001
// type 4 reads the key memory back
00002 00004 00000   00001 10100
// zero padding and an unknown type, no reply
00009 00000 00000 00007 00005 00011 00022 00033 00044 00055   00000
00002 00003 00000   00001 20040
// six bytes to seed, the last two are dropped
00008 00002 00006 000de 000ad 000be 000ef 00012 00034   00001 00001
00002 00003 00000   00005 000de 000ad 000be 000ef 2043c
// end of records
00000

/* tb/uart_loader_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_loader_tb
    import uart_loader_pkg::*;
();
    localparam int bit_clks   = clks_per_tick * ticks_per_bit;
    localparam int frame_clks = 10 * bit_clks;
    localparam int pat_depth  = 256;

    logic clk;
    logic rst;
    logic uart_rx_in;
    logic uart_tx_out;

    // entry 000xx literal, 1nnnn random run, 2ssnn fill run from index ss
    logic [19:0] pat [pat_depth];
    byte_t       frame_q [$];
    byte_t       exp_q [$];
    byte_t       rand_q [$];
    byte_t       got_q [$];
    integer      seed;
    int          errors;
    longint      watch_ns;

    uart_loader_top uart_loader_top_inst (
        .clk         (clk),
        .rst         (rst),
        .uart_rx_in  (uart_rx_in),
        .uart_tx_out (uart_tx_out)
    );

    initial clk = 1'b0;

    always #10 clk = ~clk;

    function automatic int entry_len(input logic [19:0] e);
        case (e[19:16])
            4'h1:    return int'(e[15:0]);
            4'h2:    return int'(e[7:0]);
            default: return 1;
        endcase
    endfunction

    // seed fill data that depends on every index bit
    function automatic byte_t fill_byte(input int idx);
        return byte_t'(idx * 29 + 7);
    endfunction

    task automatic add_frame_entry(input logic [19:0] e);
        byte_t b;
        int    i;
        case (e[19:16])
            4'h1:
                for (i = 0; i < int'(e[15:0]); i++)
                begin
                    b = byte_t'($random(seed));
                    rand_q.push_back(b);
                    frame_q.push_back(b);
                end
            4'h2:
                for (i = 0; i < int'(e[7:0]); i++)
                begin
                    frame_q.push_back(fill_byte(int'(e[15:8]) + i));
                end
            default: frame_q.push_back(e[7:0]);
        endcase
    endtask

    task automatic add_reply_entry(input logic [19:0] e);
        int i;
        case (e[19:16])
            // random bytes come back in the order they were sent
            4'h1:
                for (i = 0; i < int'(e[15:0]); i++)
                begin
                    if (rand_q.size() > 0)
                    begin
                        exp_q.push_back(rand_q.pop_front());
                    end
                end
            4'h2:
                for (i = 0; i < int'(e[7:0]); i++)
                begin
                    exp_q.push_back(fill_byte(int'(e[15:8]) + i));
                end
            default: exp_q.push_back(e[7:0]);
        endcase
    endtask

    // 8N1 with the start bit first and data lsb first
    task automatic send_byte(input byte_t b);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            @(posedge clk);
            uart_rx_in <= bits[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
    endtask

    task automatic check_replies(input int rec);
        int    idx;
        int    waited;
        byte_t got;
        byte_t want;
        idx = 0;
        while (exp_q.size() > 0)
        begin
            want   = exp_q.pop_front();
            waited = 0;
            while (got_q.size() == 0 && waited < 3 * frame_clks)
            begin
                @(posedge clk);
                waited++;
            end
            if (got_q.size() == 0)
            begin
                $display("record %0d: reply byte %0d never arrived on uart_tx_out", rec, idx);
                errors++;
                exp_q.delete();
            end
            else
            begin
                got = got_q.pop_front();
                if (got !== want)
                begin
                    $display("** Error: uart_tx_out record %0d byte %0d: got 0x%02h, expected 0x%02h",
                             rec, idx, got, want);
                    errors++;
                end
            end
            idx++;
        end
        // extra bytes would show up within two frame times
        repeat (2 * frame_clks) @(posedge clk);
        if (got_q.size() != 0)
        begin
            $display("record %0d: %0d reply bytes more than expected", rec, got_q.size());
            errors++;
            got_q.delete();
        end
    endtask

    // reply bytes taken from the bit middles of the transmit line
    initial
    begin : tx_monitor
        byte_t b;
        int    i;
        wait (rst === 1'b0);
        forever
        begin
            @(negedge clk);
            if (uart_tx_out === 1'b0)
            begin
                repeat (bit_clks / 2) @(negedge clk);
                for (i = 0; i < 8; i++)
                begin
                    repeat (bit_clks) @(negedge clk);
                    b[i] = uart_tx_out;
                end
                repeat (bit_clks) @(negedge clk);
                if (uart_tx_out !== 1'b1)
                begin
                    $display("stop bit on uart_tx_out was low at %0t", $time);
                    errors++;
                end
                got_q.push_back(b);
            end
        end
    end

    initial
    begin : watchdog
        wait (watch_ns != 0);
        #(watch_ns);
        $display("watchdog expired after %0d ns, the run is stuck", watch_ns);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin : main_flow
        int ptr;
        int n;
        int i;
        int k;
        int r;
        int total;
        int records;
        rst        = 1'b1;
        uart_rx_in = 1'b1;
        seed       = 32'hc439_590b;
        errors     = 0;
        watch_ns   = 0;
        $readmemh("tb/uart_loader_patterns.txt", pat);

        // count bytes both ways to size the watchdog
        ptr     = 0;
        total   = 0;
        records = 0;
        while (ptr < pat_depth && pat[ptr] != 20'h0)
        begin
            for (k = 0; k < 2; k++)
            begin
                n = int'(pat[ptr]);
                ptr++;
                for (i = 0; i < n; i++)
                begin
                    total += entry_len(pat[ptr]);
                    ptr++;
                end
            end
            records++;
        end
        watch_ns = longint'(total + 2 * records + 2) * frame_clks * 20 * 2;
        if (records == 0)
        begin
            $display("no records found in the pattern file");
            errors++;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (bit_clks) @(posedge clk);

        ptr = 0;
        for (r = 0; r < records; r++)
        begin
            frame_q.delete();
            exp_q.delete();
            n = int'(pat[ptr]);
            ptr++;
            for (i = 0; i < n; i++)
            begin
                add_frame_entry(pat[ptr]);
                ptr++;
            end
            n = int'(pat[ptr]);
            ptr++;
            for (i = 0; i < n; i++)
            begin
                add_reply_entry(pat[ptr]);
                ptr++;
            end
            while (frame_q.size() > 0)
            begin
                send_byte(frame_q.pop_front());
            end
            check_replies(r);
        end

        errors += uart_loader_top_inst.uart_loader_asserts_inst.fail_count;
        $display("%0d records run, %0d errors", records, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart/uart_baud_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_baud_gen
    import uart_loader_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic tick
);
    localparam int cnt_w = $clog2(clks_per_tick);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            tick <= 1'b0;
            if (cnt == cnt_w'(clks_per_tick - 1))
            begin
                cnt  <= '0;
                tick <= 1'b1;
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import uart_loader_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  tick,
    input  logic  rx,
    output logic  rx_valid,
    output byte_t rx_byte
);
    localparam int half_bit  = ticks_per_bit / 2;
    // release a little before the end of the stop bit
    localparam int stop_last = ticks_per_bit + half_bit - 3;

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t     state;
    logic       rx_meta;
    logic       rx_sync;
    logic [4:0] tick_cnt;
    logic [2:0] bit_cnt;
    byte_t      shreg;
    logic       stop_ok;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state)
                st_idle:
                    if (!rx_sync)
                    begin
                        tick_cnt <= '0;
                        state    <= st_start;
                    end
                st_start:
                    if (tick)
                    begin
                        if (tick_cnt == 5'(half_bit - 1))
                        begin
                            // a high line in the middle of the start bit was a glitch
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_sync ? st_idle : st_data;
                        end
                        else
                        begin
                            tick_cnt <= tick_cnt + 5'd1;
                        end
                    end
                st_data:
                    if (tick)
                    begin
                        if (tick_cnt == 5'(ticks_per_bit - 1))
                        begin
                            tick_cnt <= '0;
                            shreg    <= {rx_sync, shreg[7:1]};
                            bit_cnt  <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                state <= st_stop;
                            end
                        end
                        else
                        begin
                            tick_cnt <= tick_cnt + 5'd1;
                        end
                    end
                st_stop:
                    if (tick)
                    begin
                        tick_cnt <= tick_cnt + 5'd1;
                        if (tick_cnt == 5'(ticks_per_bit - 1))
                        begin
                            stop_ok <= rx_sync;
                        end
                        if (tick_cnt == 5'(stop_last))
                        begin
                            // low stop bit drops the frame
                            rx_valid <= stop_ok;
                            rx_byte  <= shreg;
                            state    <= st_idle;
                        end
                    end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import uart_loader_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  tick,
    input  logic  tx_start,
    input  byte_t tx_byte,
    output logic  tx,
    output logic  tx_busy,
    output logic  tx_done
);
    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t     state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    byte_t      shreg;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= st_idle;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
            tx_done  <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            tx_done <= 1'b0;
            case (state)
                st_idle:
                    if (tx_start)
                    begin
                        shreg    <= tx_byte;
                        tx       <= 1'b0;
                        tx_busy  <= 1'b1;
                        tick_cnt <= '0;
                        state    <= st_start;
                    end
                st_start:
                    if (tick)
                    begin
                        tick_cnt <= tick_cnt + 4'd1;
                        if (tick_cnt == 4'(ticks_per_bit - 1))
                        begin
                            tx      <= shreg[0];
                            bit_cnt <= '0;
                            state   <= st_data;
                        end
                    end
                st_data:
                    if (tick)
                    begin
                        tick_cnt <= tick_cnt + 4'd1;
                        if (tick_cnt == 4'(ticks_per_bit - 1))
                        begin
                            // lsb first
                            shreg   <= {1'b0, shreg[7:1]};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                tx    <= 1'b1;
                                state <= st_stop;
                            end
                            else
                            begin
                                tx <= shreg[1];
                            end
                        end
                    end
                st_stop:
                    if (tick)
                    begin
                        tick_cnt <= tick_cnt + 4'd1;
                        if (tick_cnt == 4'(ticks_per_bit - 1))
                        begin
                            tx_busy <= 1'b0;
                            tx_done <= 1'b1;
                            state   <= st_idle;
                        end
                    end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire
